/* design/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

  localparam int NUM_WAYS       = 2;
  localparam int NUM_SETS       = 8;
  localparam int WORDS_PER_LINE = 2;
  localparam int TAG_W          = 26;
  localparam int INDEX_W        = 3;

  typedef logic [31:0]        word_t;
  typedef logic [TAG_W-1:0]   tag_t;   // addr[31:6]
  typedef logic [INDEX_W-1:0] index_t; // addr[5:3]
  typedef logic               way_t;

  typedef struct packed {
    logic valid;
    logic dirty;
    tag_t tag;
  } line_meta_t;

  typedef struct packed {
    logic  ren;
    logic  wen;
    logic  halt;
    word_t addr;
    word_t store;
  } cpu_req_t;

  typedef struct packed {
    logic  hit;
    word_t load;
    logic  flushed;
  } cpu_rsp_t;

  typedef struct packed {
    logic  ren;
    logic  wen;
    word_t addr;
    word_t store;
  } mem_req_t;

  typedef struct packed {
    logic       en;
    way_t       way;
    index_t     index;
    line_meta_t meta;
  } meta_wr_t;

  typedef struct packed {
    logic   en;
    way_t   way;
    index_t index;
    logic   word_sel;
    word_t  data;
  } data_wr_t;

  function automatic tag_t addr_tag(word_t addr);
    return addr[31:32-TAG_W];
  endfunction

  function automatic index_t addr_index(word_t addr);
    return addr[5:3];
  endfunction

  function automatic logic addr_word(word_t addr);
    return addr[2];
  endfunction

  // byte address of one word of a line
  function automatic word_t line_addr(tag_t tag, index_t index, logic word_sel);
    return {tag, index, word_sel, 2'b00};
  endfunction

endpackage

`default_nettype wire

/* design/dcache_data_array.sv */
`default_nettype none

module dcache_data_array import dcache_pkg::*; (
  input  logic     CLK,
  input  logic     nRST,
  input  way_t     rd_way,
  input  index_t   rd_index,
  input  logic     rd_word,
  output word_t    rd_data,
  input  data_wr_t data_wr
);

  word_t data_q [NUM_WAYS][NUM_SETS][WORDS_PER_LINE];

  // async read, feeds hit loads and writeback stores
  assign rd_data = data_q[rd_way][rd_index][rd_word];

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      for (int w = 0; w < NUM_WAYS; w++)
      begin
        for (int s = 0; s < NUM_SETS; s++)
        begin
          for (int k = 0; k < WORDS_PER_LINE; k++)
          begin
            data_q[w][s][k] <= '0;
          end
        end
      end
    end
    else if (data_wr.en)
    begin
      data_q[data_wr.way][data_wr.index][data_wr.word_sel] <= data_wr.data;
    end
  end

endmodule

`default_nettype wire

/* design/dcache_tag_array.sv */
`default_nettype none

module dcache_tag_array import dcache_pkg::*; (
  input  logic                      CLK,
  input  logic                      nRST,
  input  index_t                    lookup_index,
  input  tag_t                      lookup_tag,
  output line_meta_t [NUM_WAYS-1:0] meta,
  output logic                      hit,
  output way_t                      hit_way,
  output way_t                      victim_way,
  input  meta_wr_t                  meta_wr,
  input  logic                      lru_touch,
  input  way_t                      touch_way
);

  line_meta_t            meta_q [NUM_WAYS][NUM_SETS];
  logic [NUM_SETS-1:0]   lru_q; // per set, way to replace next
  logic [NUM_WAYS-1:0]   way_match;

  always_comb
  begin
    for (int w = 0; w < NUM_WAYS; w++)
    begin
      meta[w]      = meta_q[w][lookup_index];
      way_match[w] = meta[w].valid && (meta[w].tag == lookup_tag);
    end
  end

  assign hit     = |way_match;
  assign hit_way = way_match[1] && !way_match[0];

  // first invalid way wins, else LRU
  assign victim_way = !meta[0].valid ? 1'b0 :
                      !meta[1].valid ? 1'b1 :
                      lru_q[lookup_index];

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      for (int w = 0; w < NUM_WAYS; w++)
      begin
        for (int s = 0; s < NUM_SETS; s++)
        begin
          meta_q[w][s] <= '0;
        end
      end
      lru_q <= '0;
    end
    else
    begin
      if (meta_wr.en)
        meta_q[meta_wr.way][meta_wr.index] <= meta_wr.meta;
      if (lru_touch)
        lru_q[lookup_index] <= !touch_way; // other way is now the older one
    end
  end

endmodule

`default_nettype wire

/* design/dcache_ctrl.sv */
`default_nettype none

module dcache_ctrl import dcache_pkg::*; (
  input  logic                      CLK,
  input  logic                      nRST,
  input  cpu_req_t                  cpu_req,
  output cpu_rsp_t                  cpu_rsp,
  output mem_req_t                  mem_req,
  input  logic                      dwait,
  input  word_t                     dload,
  output index_t                    lookup_index,
  input  line_meta_t [NUM_WAYS-1:0] meta,
  input  logic                      hit,
  input  way_t                      hit_way,
  input  way_t                      victim_way,
  output meta_wr_t                  meta_wr,
  output logic                      lru_touch,
  output way_t                      touch_way,
  output way_t                      rd_way,
  output index_t                    rd_index,
  output logic                      rd_word,
  input  word_t                     rd_data,
  output data_wr_t                  data_wr
);

  typedef enum logic [3:0] {
    IDLE, WB0, WB1, FILL0, FILL1, FLUSH_CHK, FLUSH_W0, FLUSH_W1, FLUSHED
  } state_t;

  localparam logic [3:0] LAST_LINE = 4'(NUM_SETS * NUM_WAYS - 1);

  state_t     state_q, state_d;
  way_t       vict_q, vict_d;         // fixed from miss entry to fill end
  logic [3:0] flush_cnt_q, flush_cnt_d; // {set, way}

  tag_t       req_tag;
  index_t     req_index;
  logic       req_word;
  logic       in_flush;
  line_meta_t vict_line;
  line_meta_t flush_line;

  assign req_tag    = addr_tag(cpu_req.addr);
  assign req_index  = addr_index(cpu_req.addr);
  assign req_word   = addr_word(cpu_req.addr);
  assign in_flush   = (state_q == FLUSH_CHK) || (state_q == FLUSH_W0) || (state_q == FLUSH_W1);
  assign vict_line  = meta[vict_q];
  assign flush_line = meta[flush_cnt_q[0]];

  assign lookup_index = in_flush ? flush_cnt_q[3:1] : req_index;
  assign rd_index     = lookup_index;

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      state_q     <= IDLE;
      vict_q      <= 1'b0;
      flush_cnt_q <= '0;
    end
    else
    begin
      state_q     <= state_d;
      vict_q      <= vict_d;
      flush_cnt_q <= flush_cnt_d;
    end
  end

  always_comb
  begin
    state_d     = state_q;
    vict_d      = vict_q;
    flush_cnt_d = flush_cnt_q;
    cpu_rsp     = '0;
    mem_req     = '0;
    meta_wr     = '0;
    data_wr     = '0;
    lru_touch   = 1'b0;
    touch_way   = hit_way;
    rd_way      = hit_way;
    rd_word     = req_word;
    cpu_rsp.flushed = (state_q == FLUSHED);

    case (state_q)
      IDLE:
      begin
        if (cpu_req.ren || cpu_req.wen)
        begin
          if (hit)
          begin
            cpu_rsp.hit  = 1'b1;
            cpu_rsp.load = rd_data;
            lru_touch    = 1'b1;
            if (cpu_req.wen)
            begin
              data_wr = '{en: 1'b1, way: hit_way, index: req_index,
                          word_sel: req_word, data: cpu_req.store};
              meta_wr = '{en: 1'b1, way: hit_way, index: req_index,
                          meta: '{valid: 1'b1, dirty: 1'b1, tag: req_tag}};
            end
          end
          else
          begin
            vict_d = victim_way;
            if (meta[victim_way].valid && meta[victim_way].dirty)
              state_d = WB0;
            else
              state_d = FILL0;
          end
        end
        else if (cpu_req.halt)
        begin
          flush_cnt_d = '0;
          state_d     = FLUSH_CHK;
        end
      end

      WB0, WB1:
      begin
        rd_way        = vict_q;
        rd_word       = (state_q == WB1);
        mem_req.wen   = 1'b1;
        mem_req.addr  = line_addr(vict_line.tag, req_index, rd_word);
        mem_req.store = rd_data;
        if (!dwait)
          state_d = (state_q == WB0) ? WB1 : FILL0;
      end

      FILL0:
      begin
        rd_way       = vict_q;
        mem_req.ren  = 1'b1;
        mem_req.addr = line_addr(req_tag, req_index, req_word);
        if (!dwait)
        begin
          // a write miss puts its store word in place of the fetched one
          data_wr = '{en: 1'b1, way: vict_q, index: req_index, word_sel: req_word,
                      data: cpu_req.wen ? cpu_req.store : dload};
          state_d = FILL1;
        end
      end

      FILL1:
      begin
        rd_way       = vict_q;
        touch_way    = vict_q;
        mem_req.ren  = 1'b1;
        mem_req.addr = line_addr(req_tag, req_index, !req_word);
        if (!dwait)
        begin
          data_wr = '{en: 1'b1, way: vict_q, index: req_index,
                      word_sel: !req_word, data: dload};
          meta_wr = '{en: 1'b1, way: vict_q, index: req_index,
                      meta: '{valid: 1'b1, dirty: cpu_req.wen, tag: req_tag}};
          lru_touch    = 1'b1;
          cpu_rsp.hit  = 1'b1;
          cpu_rsp.load = rd_data; // requested word landed in FILL0
          state_d      = IDLE;
        end
      end

      FLUSH_CHK, FLUSH_W0, FLUSH_W1:
      begin
        rd_way        = flush_cnt_q[0];
        rd_word       = (state_q == FLUSH_W1);
        mem_req.wen   = (state_q != FLUSH_CHK);
        mem_req.addr  = line_addr(flush_line.tag, flush_cnt_q[3:1], rd_word);
        mem_req.store = rd_data;
        if (state_q == FLUSH_CHK && flush_line.valid && flush_line.dirty)
          state_d = FLUSH_W0;
        else if (state_q == FLUSH_W0)
        begin
          if (!dwait)
            state_d = FLUSH_W1;
        end
        else if (state_q == FLUSH_CHK || !dwait)
        begin
          // line done, drop it and move on
          meta_wr = '{en: 1'b1, way: flush_cnt_q[0], index: flush_cnt_q[3:1],
                      meta: '{valid: 1'b0, dirty: 1'b0, tag: flush_line.tag}};
          if (flush_cnt_q == LAST_LINE)
            state_d = FLUSHED;
          else
          begin
            flush_cnt_d = flush_cnt_q + 4'd1;
            state_d     = FLUSH_CHK;
          end
        end
      end

      FLUSHED:
      begin
        state_d = FLUSHED; // held until reset
      end

      default:
      begin
        state_d = IDLE;
      end
    endcase
  end

endmodule

`default_nettype wire

/* design/dcache_top.sv */
`default_nettype none

module dcache_top import dcache_pkg::*; (
  input  logic     CLK,
  input  logic     nRST,
  input  cpu_req_t cpu_req,
  output cpu_rsp_t cpu_rsp,
  output mem_req_t mem_req,
  input  logic     dwait,
  input  word_t    dload
);

  index_t                    lookup_index;
  line_meta_t [NUM_WAYS-1:0] meta;
  logic                      hit;
  way_t                      hit_way;
  way_t                      victim_way;
  meta_wr_t                  meta_wr;
  logic                      lru_touch;
  way_t                      touch_way;
  way_t                      rd_way;
  index_t                    rd_index;
  logic                      rd_word;
  word_t                     rd_data;
  data_wr_t                  data_wr;

  dcache_ctrl ctrl_i (
    .CLK          (CLK),
    .nRST         (nRST),
    .cpu_req      (cpu_req),
    .cpu_rsp      (cpu_rsp),
    .mem_req      (mem_req),
    .dwait        (dwait),
    .dload        (dload),
    .lookup_index (lookup_index),
    .meta         (meta),
    .hit          (hit),
    .hit_way      (hit_way),
    .victim_way   (victim_way),
    .meta_wr      (meta_wr),
    .lru_touch    (lru_touch),
    .touch_way    (touch_way),
    .rd_way       (rd_way),
    .rd_index     (rd_index),
    .rd_word      (rd_word),
    .rd_data      (rd_data),
    .data_wr      (data_wr)
  );

  dcache_tag_array tags_i (
    .CLK          (CLK),
    .nRST         (nRST),
    .lookup_index (lookup_index),
    .lookup_tag   (addr_tag(cpu_req.addr)), // compare always against the CPU tag
    .meta         (meta),
    .hit          (hit),
    .hit_way      (hit_way),
    .victim_way   (victim_way),
    .meta_wr      (meta_wr),
    .lru_touch    (lru_touch),
    .touch_way    (touch_way)
  );

  dcache_data_array data_i (
    .CLK      (CLK),
    .nRST     (nRST),
    .rd_way   (rd_way),
    .rd_index (rd_index),
    .rd_word  (rd_word),
    .rd_data  (rd_data),
    .data_wr  (data_wr)
  );

endmodule

`default_nettype wire

/* dv/dcache_mem_model.sv */
`default_nettype none

module dcache_mem_model import dcache_pkg::*; (
  input  logic     CLK,
  input  logic     nRST,
  input  mem_req_t mem_req,
  output logic     dwait,
  output word_t    dload
);

  timeunit 1ns;
  timeprecision 1ps;

  word_t       mem [4096];
  logic [1:0]  wait_cnt; // wait cycles left before the current word completes
  logic [11:0] widx;

  function automatic word_t fill_word(int idx);
    return {4'ha, idx[11:0], 4'h5, ~idx[11:0]};
  endfunction

  initial
  begin
    for (int i = 0; i < 4096; i++)
    begin
      mem[i] = fill_word(i);
    end
  end

  assign widx  = mem_req.addr[13:2]; // word address
  assign dwait = (mem_req.ren || mem_req.wen) && (wait_cnt != 2'd0);
  assign dload = mem[widx];

  always @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
      wait_cnt <= 2'd0;
    else if (mem_req.ren || mem_req.wen)
    begin
      if (wait_cnt != 2'd0)
        wait_cnt <= wait_cnt - 2'd1;
      else
        wait_cnt <= 2'($urandom % 4); // delay of the next word
    end
  end

  always @(posedge CLK)
  begin
    if (mem_req.wen && !dwait)
      mem[widx] <= mem_req.store;
  end

endmodule

`default_nettype wire

/* dv/dcache_chk.sv */
`default_nettype none

module dcache_chk import dcache_pkg::*; (
  input logic     CLK,
  input logic     nRST,
  input mem_req_t mem_req,
  input logic     dwait,
  input cpu_rsp_t cpu_rsp
);

  timeunit 1ns;
  timeprecision 1ps;

  int fail_cnt = 0;

  mem_excl_a: assert property (@(posedge CLK) disable iff (!nRST)
    !(mem_req.ren && mem_req.wen))
  else
  begin
    $error("memory read and write requested in the same cycle");
    fail_cnt++;
  end

  flushed_hold_a: assert property (@(posedge CLK) disable iff (!nRST)
    cpu_rsp.flushed |=> cpu_rsp.flushed)
  else
  begin
    $error("flushed fell while out of reset");
    fail_cnt++;
  end

  // request must hold still while memory stalls
  mem_stable_a: assert property (@(posedge CLK) disable iff (!nRST)
    (mem_req.ren || mem_req.wen) && dwait |=>
      $stable(mem_req.ren) && $stable(mem_req.wen) &&
      $stable(mem_req.addr) && $stable(mem_req.store))
  else
  begin
    $error("memory request changed during a wait state");
    fail_cnt++;
  end

endmodule

bind dcache_top dcache_chk chk_i (
  .CLK     (CLK),
  .nRST    (nRST),
  .mem_req (mem_req),
  .dwait   (dwait),
  .cpu_rsp (cpu_rsp)
);

`default_nettype wire

/* dv/dcache_tb.sv */
`default_nettype none

module dcache_tb import dcache_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  logic     CLK = 1'b0;
  logic     nRST;
  cpu_req_t cpu_req;
  cpu_rsp_t cpu_rsp;
  mem_req_t mem_req;
  logic     dwait;
  word_t    dload;

  int errors       = 0;
  int tests_run    = 0;
  int tests_failed = 0;
  int cycle_cnt    = 0;

  logic  m_valid [2][8];
  logic  m_dirty [2][8];
  tag_t  m_tag   [2][8];
  way_t  m_lru   [8];      // way to replace next
  word_t cpu_view [4096];  // latest value the CPU should read
  word_t mem_exp  [4096];  // expected memory contents

  dcache_top dut_i (
    .CLK     (CLK),
    .nRST    (nRST),
    .cpu_req (cpu_req),
    .cpu_rsp (cpu_rsp),
    .mem_req (mem_req),
    .dwait   (dwait),
    .dload   (dload)
  );

  dcache_mem_model mem_i (
    .CLK     (CLK),
    .nRST    (nRST),
    .mem_req (mem_req),
    .dwait   (dwait),
    .dload   (dload)
  );

  always #50 CLK = ~CLK;

  // about 700 cycles needed in the worst case
  always @(posedge CLK)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == 4000)
    begin
      $display("Timeout: the run did not finish within 4000 cycles");
      $display("Errors found");
      $finish;
    end
  end

  function automatic int word_idx(word_t addr);
    return int'(addr[13:2]);
  endfunction

  function automatic word_t initial_word(int idx);
    return {4'ha, idx[11:0], 4'h5, ~idx[11:0]};
  endfunction

  function automatic void model_reset();
    for (int s = 0; s < 8; s++)
    begin
      for (int w = 0; w < 2; w++)
      begin
        m_valid[w][s] = 1'b0;
        m_dirty[w][s] = 1'b0;
        m_tag[w][s]   = '0;
      end
      m_lru[s] = 1'b0;
    end
    for (int i = 0; i < 4096; i++)
    begin
      cpu_view[i] = initial_word(i);
      mem_exp[i]  = cpu_view[i];
    end
  endfunction

  function automatic void write_back(way_t w, index_t s);
    int idx;
    for (int k = 0; k < 2; k++)
    begin
      idx = word_idx({m_tag[w][s], s, 1'(k), 2'b00});
      mem_exp[idx] = cpu_view[idx];
    end
  endfunction

  task automatic model_access(input logic wr, input word_t addr, input word_t data,
                              output logic hit_exp);
    index_t s;
    tag_t   t;
    way_t   w;
    s = addr[5:3];
    t = addr[31:6];
    w = 1'b0;
    hit_exp = 1'b0;
    for (int i = 0; i < 2; i++)
    begin
      if (m_valid[i][s] && m_tag[i][s] == t)
      begin
        hit_exp = 1'b1;
        w = 1'(i);
      end
    end
    if (!hit_exp)
    begin
      w = !m_valid[0][s] ? 1'b0 : !m_valid[1][s] ? 1'b1 : m_lru[s]; // victim
      if (m_valid[w][s] && m_dirty[w][s])
        write_back(w, s);
      m_valid[w][s] = 1'b1;
      m_dirty[w][s] = 1'b0;
      m_tag[w][s]   = t;
    end
    if (wr)
    begin
      cpu_view[word_idx(addr)] = data;
      m_dirty[w][s] = 1'b1;
    end
    m_lru[s] = !w;
  endtask

  function automatic void model_flush();
    for (int s = 0; s < 8; s++)
    begin
      for (int w = 0; w < 2; w++)
      begin
        if (m_valid[w][s] && m_dirty[w][s])
          write_back(1'(w), 3'(s));
        m_valid[w][s] = 1'b0;
        m_dirty[w][s] = 1'b0;
      end
    end
  endfunction

  task automatic do_access(input logic wr, input word_t addr, input word_t data,
                           output word_t load, output int cycles);
    @(posedge CLK);
    cpu_req <= '{ren: !wr, wen: wr, halt: 1'b0, addr: addr, store: data};
    @(negedge CLK);
    cycles = 1;
    while (!cpu_rsp.hit)
    begin
      @(negedge CLK);
      cycles++;
    end
    load = cpu_rsp.load;
    @(posedge CLK);
    cpu_req <= '0; // drop after the hit strobe
  endtask

  task automatic check_access(input string name, input logic wr, input word_t addr,
                              input word_t data);
    logic  hit_exp;
    word_t load;
    word_t load_exp;
    int    cycles;
    model_access(wr, addr, data, hit_exp);
    load_exp = cpu_view[word_idx(addr)];
    do_access(wr, addr, data, load, cycles);
    if (!wr && load !== load_exp)
    begin
      $display("Error: %s: load at %h expected %h actual %h", name, addr, load_exp, load);
      errors++;
    end
    if (hit_exp && cycles != 1)
    begin
      $display("Error: %s: hit cycles at %h expected 1 actual %0d", name, addr, cycles);
      errors++;
    end
    if (!hit_exp && cycles == 1)
    begin
      $display("Error: %s: access at %h hit at once although it should miss", name, addr);
      errors++;
    end
  endtask

  task automatic compare_memory(input string name);
    for (int i = 0; i < 4096; i++)
    begin
      if (mem_i.mem[i] !== mem_exp[i])
      begin
        $display("Error: %s: memory at %h expected %h actual %h",
                 name, i * 4, mem_exp[i], mem_i.mem[i]);
        errors++;
      end
    end
  endtask

  task automatic finish_test(input string name, input int start_errors);
    tests_run++;
    if (errors == start_errors)
      $display("%s: pass", name);
    else
    begin
      tests_failed++;
      $display("%s: fail with %0d errors", name, errors - start_errors);
    end
  endtask

  task automatic test_reset_read_miss();
    int start;
    start = errors;
    if (mem_req.ren || mem_req.wen || cpu_rsp.hit || cpu_rsp.flushed)
    begin
      $display("Error: reset_read_miss: ren wen hit flushed expected 0000 actual %b",
               {mem_req.ren, mem_req.wen, cpu_rsp.hit, cpu_rsp.flushed});
      errors++;
    end
    check_access("reset_read_miss", 1'b0, 32'h0000_0100, '0);
    check_access("reset_read_miss", 1'b0, 32'h0000_0100, '0);
    compare_memory("reset_read_miss");
    finish_test("reset_read_miss", start);
  endtask

  task automatic test_write_hit();
    int start;
    start = errors;
    check_access("write_hit", 1'b1, 32'h0000_0100, 32'h1111_0100);
    check_access("write_hit", 1'b1, 32'h0000_0104, 32'h2222_0104);
    check_access("write_hit", 1'b0, 32'h0000_0100, '0);
    check_access("write_hit", 1'b0, 32'h0000_0104, '0);
    compare_memory("write_hit"); // still the initial words
    finish_test("write_hit", start);
  endtask

  task automatic test_write_miss();
    int start;
    start = errors;
    check_access("write_miss", 1'b1, 32'h0000_0218, 32'hcafe_0218);
    check_access("write_miss", 1'b0, 32'h0000_0218, '0);
    check_access("write_miss", 1'b0, 32'h0000_021c, '0);
    compare_memory("write_miss");
    finish_test("write_miss", start);
  endtask

  task automatic test_evict_lru();
    int start;
    start = errors;
    check_access("evict_lru", 1'b1, 32'h0000_1028, 32'hdead_1028); // set 5, way 0
    check_access("evict_lru", 1'b0, 32'h0000_2028, '0);             // way 1
    check_access("evict_lru", 1'b0, 32'h0000_3028, '0);             // evicts dirty way 0
    if (mem_i.mem[word_idx(32'h0000_1028)] !== 32'hdead_1028)
    begin
      $display("Error: evict_lru: written back word expected %h actual %h",
               32'hdead_1028, mem_i.mem[word_idx(32'h0000_1028)]);
      errors++;
    end
    compare_memory("evict_lru");
    check_access("evict_lru", 1'b0, 32'h0000_1028, '0);
    check_access("evict_lru", 1'b0, 32'h0000_3028, '0);
    check_access("evict_lru", 1'b0, 32'h0000_2028, '0);
    compare_memory("evict_lru");
    finish_test("evict_lru", start);
  endtask

  task automatic test_flush();
    int start;
    start = errors;
    check_access("flush", 1'b1, 32'h0000_0040, 32'h5151_0040);
    check_access("flush", 1'b1, 32'h0000_0058, 32'h5252_0058);
    check_access("flush", 1'b1, 32'h0000_00f0, 32'h5353_00f0);
    check_access("flush", 1'b1, 32'h0000_0104, 32'h5454_0104);
    @(posedge CLK);
    cpu_req <= '{ren: 1'b0, wen: 1'b0, halt: 1'b1, addr: '0, store: '0};
    @(negedge CLK);
    while (!cpu_rsp.flushed)
    begin
      @(negedge CLK);
    end
    model_flush();
    compare_memory("flush");
    @(posedge CLK);
    cpu_req <= '{ren: 1'b1, wen: 1'b0, halt: 1'b0, addr: 32'h0000_0100, store: '0};
    repeat (4)
    begin
      @(negedge CLK);
      if (!cpu_rsp.flushed)
      begin
        $display("Error: flush: flushed expected 1 actual 0");
        errors++;
      end
      if (cpu_rsp.hit)
      begin
        $display("Error: flush: hit after flush expected 0 actual 1");
        errors++;
      end
    end
    @(posedge CLK);
    cpu_req <= '0;
    finish_test("flush", start);
  endtask

  initial
  begin
    void'($urandom(32'h9b02_e568));
    nRST    = 1'b0;
    cpu_req = '0;
    model_reset();
    repeat (2) @(posedge CLK);
    nRST <= 1'b1;
    @(negedge CLK);

    test_reset_read_miss();
    test_write_hit();
    test_write_miss();
    test_evict_lru();
    test_flush();

    if (dut_i.chk_i.fail_cnt != 0)
    begin
      $display("The bound checker saw %0d failed assertions", dut_i.chk_i.fail_cnt);
      errors += dut_i.chk_i.fail_cnt;
    end
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
design/dcache_pkg.sv
design/dcache_data_array.sv
design/dcache_tag_array.sv
design/dcache_ctrl.sv
design/dcache_top.sv
dv/dcache_mem_model.sv
dv/dcache_chk.sv
dv/dcache_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f project.f --top-module dcache_tb -o dcache_sim

./obj_dir/dcache_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log

if grep -q "Errors found" sim.log; then
  exit 1
fi
